// ==== hdl/alu.sv ====
`default_nettype none

module alu
    import isa_pkg::*;
(
    operand_if.sink ops,
    output word_t   result
);

    alu_op_t    op;
    logic [4:0] shamt;
    word_t      sum;
    word_t      diff;
    word_t      slt_res;
    word_t      sltu_res;
    word_t      sll_res;
    word_t      srl_res;
    word_t      sra_res;
    word_t      lui_res;

    assign op    = ops.alu_op;
    assign shamt = ops.src1[4:0];

    assign sum      = ops.src1 + ops.src2;
    assign diff     = ops.src1 - ops.src2;
    assign slt_res  = word_t'($signed(ops.src1) < $signed(ops.src2));
    assign sltu_res = word_t'(ops.src1 < ops.src2);
    assign sll_res  = ops.src2 << shamt;
    assign srl_res  = ops.src2 >> shamt;
    assign sra_res  = word_t'($signed(ops.src2) >>> shamt);
    assign lui_res  = {ops.src2[15:0], 16'b0};

    // one-hot select, zero op gives zero
    assign result = ({word_w{op[alu_add ]}} & sum)
                  | ({word_w{op[alu_sub ]}} & diff)
                  | ({word_w{op[alu_slt ]}} & slt_res)
                  | ({word_w{op[alu_sltu]}} & sltu_res)
                  | ({word_w{op[alu_and ]}} & (ops.src1 & ops.src2))
                  | ({word_w{op[alu_nor ]}} & ~(ops.src1 | ops.src2))
                  | ({word_w{op[alu_or  ]}} & (ops.src1 | ops.src2))
                  | ({word_w{op[alu_xor ]}} & (ops.src1 ^ ops.src2))
                  | ({word_w{op[alu_sll ]}} & sll_res)
                  | ({word_w{op[alu_srl ]}} & srl_res)
                  | ({word_w{op[alu_sra ]}} & sra_res)
                  | ({word_w{op[alu_lui ]}} & lui_res);

    op_onehot: assert property (
        @(posedge ops.clk) $onehot0(op)
    ) else $error("alu_op is not one-hot");

endmodule

`default_nettype wire

// ==== hdl/exe_stage_reg.sv ====
`default_nettype none

module exe_stage_reg
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  exe_inst_t in_inst,
    output logic      in_allowin,
    input  logic      out_allowin,
    output logic      out_valid,
    output logic      fire,
    output exe_inst_t inst
);

    logic      valid;
    logic      accept;
    exe_inst_t inst_r;

    assign fire       = valid && out_allowin;   // leaves at this edge
    assign in_allowin = !valid || fire;         // nothing stalls inside the stage
    assign accept     = in_valid && in_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_r <= in_inst;
        end
    end

    assign out_valid = valid;
    assign inst      = inst_r;

    // a held instruction must not change under back-pressure
    hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        (valid && !out_allowin) |=> $stable(inst_r)
    ) else $error("payload changed while stalled");

endmodule

`default_nettype wire

// ==== hdl/exe_top.sv ====
`default_nettype none

module exe_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_allowin,
    input  alu_op_t     alu_op,
    input  logic        src1_is_sa,
    input  logic        src1_is_pc,
    input  logic        src2_is_imm,
    input  logic        src2_is_8,
    input  logic [15:0] imm,
    input  word_t       rs_value,
    input  word_t       rt_value,
    input  word_t       pc,
    input  reg_idx_t    dest,
    input  logic        gpr_we,
    input  logic        mem_re,
    input  logic        mem_we,
    input  ls_type_t    ls_type,
    input  hilo_op_t    hilo_op,
    input  logic        out_allowin,
    output logic        out_valid,
    output word_t       out_result,
    output reg_idx_t    out_dest,
    output logic        out_gpr_we,
    output logic        data_sram_en,
    output strb_t       data_sram_wen,
    output word_t       data_sram_addr,
    output word_t       data_sram_wdata
);

    exe_inst_t in_inst;
    exe_inst_t inst;
    logic      fire;
    word_t     alu_result;

    operand_if ops (.clk(clk));

    assign in_inst = '{alu_op: alu_op, src1_is_sa: src1_is_sa, src1_is_pc: src1_is_pc,
                       src2_is_imm: src2_is_imm, src2_is_8: src2_is_8, imm: imm,
                       rs_value: rs_value, rt_value: rt_value, pc: pc, dest: dest,
                       gpr_we: gpr_we, mem_re: mem_re, mem_we: mem_we,
                       ls_type: ls_type, hilo_op: hilo_op};

    exe_stage_reg u_stage (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_inst(in_inst), .in_allowin(in_allowin),
        .out_allowin(out_allowin), .out_valid(out_valid), .fire(fire), .inst(inst)
    );

    operand_select u_opsel (.inst(inst), .ops(ops.source));

    alu u_alu (.ops(ops.sink), .result(alu_result));

    hilo_unit u_hilo (
        .clk(clk), .reset(reset), .fire(fire), .ops(ops.sink),
        .rs_value(inst.rs_value), .alu_result(alu_result), .result(out_result)
    );

    store_align u_store (
        .fire(fire), .mem_re(inst.mem_re), .mem_we(inst.mem_we), .ls_type(inst.ls_type),
        .addr(alu_result), .rt_value(inst.rt_value),
        .data_sram_en(data_sram_en), .data_sram_wen(data_sram_wen),
        .data_sram_wdata(data_sram_wdata)
    );

    assign data_sram_addr = alu_result;   // base plus offset
    assign out_dest       = inst.dest;
    assign out_gpr_we     = inst.gpr_we;

endmodule

`default_nettype wire

// ==== hdl/hilo_unit.sv ====
`default_nettype none

module hilo_unit
    import isa_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    fire,
    operand_if.sink ops,
    input  word_t   rs_value,
    input  word_t   alu_result,
    output word_t   result
);

    logic [word_w:0]           mul_a;
    logic [word_w:0]           mul_b;
    logic signed [2*word_w-1:0] product;
    word_t                     hi;
    word_t                     lo;

    // 33 bit operands, top bit is the sign only for mult
    assign mul_a   = {ops.hilo_op.mult & ops.src1[word_w-1], ops.src1};
    assign mul_b   = {ops.hilo_op.mult & ops.src2[word_w-1], ops.src2};
    assign product = $signed(mul_a) * $signed(mul_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (fire) begin
            if (ops.hilo_op.mult || ops.hilo_op.multu) begin
                hi <= product[2*word_w-1:word_w];
                lo <= product[word_w-1:0];
            end else if (ops.hilo_op.mthi) begin
                hi <= rs_value;
            end else if (ops.hilo_op.mtlo) begin
                lo <= rs_value;
            end
        end
    end

    // hi/lo already hold any earlier fired write
    assign result = ops.hilo_op.mfhi ? hi :
                    ops.hilo_op.mflo ? lo :
                                       alu_result;

    hilo_op_excl: assert property (
        @(posedge clk) disable iff (reset)
        fire |-> $onehot0(ops.hilo_op)
    ) else $error("more than one hi/lo operation");

endmodule

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int word_w   = 32;
    localparam int alu_op_w = 12;

    // bit positions in the one-hot alu operation field
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // bit positions in the one-hot store kind
    localparam int ls_sw  = 0;
    localparam int ls_sb  = 1;
    localparam int ls_sh  = 2;
    localparam int ls_swl = 3;
    localparam int ls_swr = 4;

    typedef logic [alu_op_w-1:0] alu_op_t;
    typedef logic [word_w-1:0]   word_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [4:0]          ls_type_t;
    typedef logic [3:0]          strb_t;

endpackage

`default_nettype wire

// ==== hdl/operand_if.sv ====
`default_nettype none

interface operand_if
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input logic clk          // only used for checks in the compute blocks
);

    word_t    src1;
    word_t    src2;
    alu_op_t  alu_op;
    hilo_op_t hilo_op;

    modport source (input clk, output src1, src2, alu_op, hilo_op);
    modport sink   (input clk, input src1, src2, alu_op, hilo_op);

endinterface

`default_nettype wire

// ==== hdl/operand_select.sv ====
`default_nettype none

module operand_select
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  exe_inst_t        inst,
    operand_if.source        ops
);

    logic  imm_zext;
    word_t imm_ext;

    // logical immediates are zero extended
    assign imm_zext = inst.alu_op[alu_and] | inst.alu_op[alu_or] | inst.alu_op[alu_xor];
    assign imm_ext  = {{(word_w-16){~imm_zext & inst.imm[15]}}, inst.imm};

    assign ops.src1 = inst.src1_is_sa ? word_t'(inst.imm[10:6]) :  // shift amount
                      inst.src1_is_pc ? inst.pc                 :
                                        inst.rs_value;
    assign ops.src2 = inst.src2_is_imm ? imm_ext       :
                      inst.src2_is_8   ? word_t'(8)    :           // link return offset
                                         inst.rt_value;

    assign ops.alu_op  = inst.alu_op;
    assign ops.hilo_op = inst.hilo_op;

    src1_sel_excl: assert property (
        @(posedge ops.clk) $onehot0({inst.src1_is_sa, inst.src1_is_pc})
    ) else $error("src1 select flags both set");

endmodule

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic mult;
        logic multu;
        logic mthi;
        logic mtlo;
        logic mfhi;
        logic mflo;
    } hilo_op_t;

    // decoded instruction as handed over by decode
    typedef struct packed {
        alu_op_t  alu_op;
        logic     src1_is_sa;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     src2_is_8;
        logic [15:0] imm;
        word_t    rs_value;
        word_t    rt_value;
        word_t    pc;
        reg_idx_t dest;
        logic     gpr_we;
        logic     mem_re;
        logic     mem_we;
        ls_type_t ls_type;
        hilo_op_t hilo_op;
    } exe_inst_t;

endpackage

`default_nettype wire

// ==== hdl/store_align.sv ====
`default_nettype none

module store_align
    import isa_pkg::*;
(
    input  logic     fire,
    input  logic     mem_re,
    input  logic     mem_we,
    input  ls_type_t ls_type,
    input  word_t    addr,
    input  word_t    rt_value,
    output logic     data_sram_en,
    output strb_t    data_sram_wen,
    output word_t    data_sram_wdata
);

    logic [1:0] a;
    strb_t      strb;
    word_t      wdata;

    assign a = addr[1:0];   // byte offset in the word

    always_comb begin
        strb  = '0;
        wdata = rt_value;
        case (1'b1)
            ls_type[ls_sw]: begin
                strb = 4'b1111;
            end
            ls_type[ls_sb]: begin
                strb  = 4'b0001 << a;
                wdata = {4{rt_value[7:0]}};
            end
            ls_type[ls_sh]: begin
                strb  = a[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rt_value[15:0]}};
            end
            ls_type[ls_swl]: begin
                strb  = 4'b1111 >> (2'd3 - a);          // bytes 0..a
                wdata = rt_value >> {2'd3 - a, 3'b000};
            end
            ls_type[ls_swr]: begin
                strb  = 4'b1111 << a;                   // bytes a..3
                wdata = rt_value << {a, 3'b000};
            end
            default: begin
                strb = '0;
            end
        endcase
    end

    // request only at the fire edge, so a stalled store writes once
    assign data_sram_en    = fire && (mem_re || mem_we);
    assign data_sram_wen   = (fire && mem_we) ? strb : 4'b0000;
    assign data_sram_wdata = wdata;

    ls_type_onehot: assert final (
        $isunknown(fire) || !(fire && mem_we) || $onehot(ls_type)
    ) else $error("store kind is not one-hot");

endmodule

`default_nettype wire

// ==== list.f ====
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/operand_if.sv
hdl/exe_stage_reg.sv
hdl/operand_select.sv
hdl/alu.sv
hdl/hilo_unit.sv
hdl/store_align.sv
hdl/exe_top.sv
testbench/tb_exe_top.sv

// ==== testbench/tb_exe_top.sv ====
`default_nettype none

module tb_exe_top
    import isa_pkg::*;
    import pipe_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int total_issue = 12 + 6 + 40 + 21 + 30;
    localparam int wd_cycles   = total_issue * 5 + 100;

    logic      clk = 1'b0;
    logic      reset, in_valid, out_allowin, stall_en;
    exe_inst_t drv, ref_inst;
    logic      in_allowin, out_valid, out_gpr_we, data_sram_en;
    word_t     out_result, data_sram_addr, data_sram_wdata;
    reg_idx_t  out_dest;
    strb_t     data_sram_wen;
    word_t     seed = 32'hcb7d_0e0e;
    word_t     stall_seed = 32'hcb7d_0e0e ^ 32'h5a5a_5a5a;   // separate stream for stalls
    word_t     ref_hi, ref_lo, exp_res;
    logic      ref_valid, ref_fire, ref_accept;
    strb_t     exp_wen;
    int        errors = 0, accepts = 0, fires = 0, tests = 0, stretch = 0;

    always #10 clk = ~clk;

    exe_top dut0 (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_allowin(in_allowin),
        .alu_op(drv.alu_op), .src1_is_sa(drv.src1_is_sa), .src1_is_pc(drv.src1_is_pc),
        .src2_is_imm(drv.src2_is_imm), .src2_is_8(drv.src2_is_8), .imm(drv.imm),
        .rs_value(drv.rs_value), .rt_value(drv.rt_value), .pc(drv.pc), .dest(drv.dest),
        .gpr_we(drv.gpr_we), .mem_re(drv.mem_re), .mem_we(drv.mem_we),
        .ls_type(drv.ls_type), .hilo_op(drv.hilo_op), .out_allowin(out_allowin),
        .out_valid(out_valid), .out_result(out_result), .out_dest(out_dest),
        .out_gpr_we(out_gpr_we), .data_sram_en(data_sram_en), .data_sram_wen(data_sram_wen),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata)
    );

    function automatic word_t lcg_step(word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t rnd();
        seed = lcg_step(seed);
        return seed;
    endfunction

    function automatic word_t ref_src1(exe_inst_t i);
        if (i.src1_is_sa) return {27'b0, i.imm[10:6]};
        if (i.src1_is_pc) return i.pc;
        return i.rs_value;
    endfunction

    function automatic word_t ref_src2(exe_inst_t i);
        logic logical;
        logical = i.alu_op[alu_and] || i.alu_op[alu_or] || i.alu_op[alu_xor];
        if (i.src2_is_imm) return logical ? {16'b0, i.imm} : {{16{i.imm[15]}}, i.imm};
        if (i.src2_is_8) return 32'd8;
        return i.rt_value;
    endfunction

    function automatic word_t ref_alu(exe_inst_t i);
        word_t a, b;
        a = ref_src1(i);
        b = ref_src2(i);
        case (1'b1)
            i.alu_op[alu_add]:  return a + b;
            i.alu_op[alu_sub]:  return a - b;
            i.alu_op[alu_slt]:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            i.alu_op[alu_sltu]: return (a < b) ? 32'd1 : 32'd0;
            i.alu_op[alu_and]:  return a & b;
            i.alu_op[alu_nor]:  return ~(a | b);
            i.alu_op[alu_or]:   return a | b;
            i.alu_op[alu_xor]:  return a ^ b;
            i.alu_op[alu_sll]:  return b << a[4:0];
            i.alu_op[alu_srl]:  return b >> a[4:0];
            i.alu_op[alu_sra]:  return $signed(b) >>> a[4:0];
            i.alu_op[alu_lui]:  return b << 16;
            default:            return 32'd0;
        endcase
    endfunction

    function automatic logic [63:0] ref_product(exe_inst_t i);
        logic [63:0] x, y;
        x = {{32{i.hilo_op.mult & i.rs_value[31]}}, i.rs_value};
        y = {{32{i.hilo_op.mult & i.rt_value[31]}}, i.rt_value};
        return x * y;   // low 64 bits are right for both signs
    endfunction

    function automatic strb_t ref_strb(ls_type_t k, logic [1:0] a);
        strb_t s;
        s = '0;
        for (int b = 0; b < 4; b++) begin
            if (k[ls_sw] || (k[ls_sb] && b == a) || (k[ls_sh] && b / 2 == a / 2) ||
                (k[ls_swl] && b <= a) || (k[ls_swr] && b >= a)) s[b] = 1'b1;
        end
        return s;
    endfunction

    function automatic word_t ref_wdata(exe_inst_t i, logic [1:0] a);
        word_t v;
        v = i.rt_value;
        if (i.ls_type[ls_sb]) return {4{v[7:0]}};
        if (i.ls_type[ls_sh]) return {2{v[15:0]}};
        if (i.ls_type[ls_swl]) return v >> (8 * (3 - int'(a)));
        if (i.ls_type[ls_swr]) return v << (8 * int'(a));
        return v;
    endfunction

    function automatic exe_inst_t mk(alu_op_t op, word_t rs, word_t rt);
        exe_inst_t i;
        i = '0;
        i.alu_op   = op;
        i.rs_value = rs;
        i.rt_value = rt;
        i.dest     = rs[4:0] ^ rt[9:5];
        i.gpr_we   = 1'b1;
        return i;
    endfunction

    // reference model of the stage, hi/lo and the handshake
    assign ref_fire   = ref_valid && out_allowin;
    assign ref_accept = in_valid && (!ref_valid || out_allowin);
    assign exp_res    = ref_inst.hilo_op.mfhi ? ref_hi :
                        ref_inst.hilo_op.mflo ? ref_lo : ref_alu(ref_inst);
    assign exp_wen    = (ref_fire && ref_inst.mem_we) ?
                        ref_strb(ref_inst.ls_type, exp_res[1:0]) : 4'b0000;

    always @(posedge clk) begin
        if (reset) begin
            ref_valid <= 1'b0;
            ref_hi    <= '0;
            ref_lo    <= '0;
        end else begin
            if (ref_fire) begin
                if (ref_inst.hilo_op.mult || ref_inst.hilo_op.multu)
                    {ref_hi, ref_lo} <= ref_product(ref_inst);
                if (ref_inst.hilo_op.mthi) ref_hi <= ref_inst.rs_value;
                if (ref_inst.hilo_op.mtlo) ref_lo <= ref_inst.rs_value;
            end
            if (ref_accept) begin
                ref_inst <= drv;
            end
            ref_valid <= ref_accept || (ref_valid && !out_allowin);
        end
    end

    // handshakes as seen on the dut ports
    always @(posedge clk) begin
        if (!reset && in_valid && in_allowin) accepts <= accepts + 1;
        if (!reset && out_valid && out_allowin) fires <= fires + 1;
    end

    task automatic report(string name, word_t expected, word_t actual);
        errors++;
        $display("FAILED %s expected %h actual %h", name, expected, actual);
    endtask

    a_valid: assert property (@(posedge clk) disable iff (reset) out_valid == ref_valid)
        else report("out_valid", $sampled(ref_valid), $sampled(out_valid));
    a_allowin: assert property (@(posedge clk) disable iff (reset)
        in_allowin == (!ref_valid || out_allowin))
        else report("in_allowin", $sampled(!ref_valid || out_allowin), $sampled(in_allowin));
    a_result: assert property (@(posedge clk) disable iff (reset)
        ref_valid |-> out_result == exp_res)
        else report("out_result", $sampled(exp_res), $sampled(out_result));
    a_dest: assert property (@(posedge clk) disable iff (reset)
        ref_valid |-> {out_gpr_we, out_dest} == {ref_inst.gpr_we, ref_inst.dest})
        else report("out_gpr_we/out_dest", $sampled({ref_inst.gpr_we, ref_inst.dest}),
                    $sampled({out_gpr_we, out_dest}));
    a_addr: assert property (@(posedge clk) disable iff (reset)
        (ref_valid && (ref_inst.mem_re || ref_inst.mem_we)) |-> data_sram_addr == exp_res)
        else report("data_sram_addr", $sampled(exp_res), $sampled(data_sram_addr));
    a_en: assert property (@(posedge clk) disable iff (reset)
        data_sram_en == (ref_fire && (ref_inst.mem_re || ref_inst.mem_we)))
        else report("data_sram_en", $sampled(ref_fire && (ref_inst.mem_re || ref_inst.mem_we)),
                    $sampled(data_sram_en));
    a_wen: assert property (@(posedge clk) disable iff (reset) data_sram_wen == exp_wen)
        else report("data_sram_wen", $sampled(exp_wen), $sampled(data_sram_wen));
    a_wdata: assert property (@(posedge clk) disable iff (reset)
        (ref_fire && ref_inst.mem_we) |-> data_sram_wdata == ref_wdata(ref_inst, exp_res[1:0]))
        else report("data_sram_wdata", $sampled(ref_wdata(ref_inst, exp_res[1:0])),
                    $sampled(data_sram_wdata));
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (ref_valid && !out_allowin) |=> ($stable(out_result) && $stable(data_sram_addr)))
        else begin
            errors++;
            $display("outputs changed while the stage was stalled");
        end

    // random stretches of back-pressure
    always @(negedge clk) begin
        if (stall_en) begin
            if (stretch == 0) begin
                out_allowin = ~out_allowin;
                stall_seed  = lcg_step(stall_seed);
                stretch     = stall_seed[17:16];
            end else begin
                stretch--;
            end
        end
    end

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic issue(exe_inst_t i);
        logic taken;
        drv      = i;
        in_valid = 1'b1;
        do begin
            #1 taken = in_allowin;
            @(negedge clk);
        end while (!taken);
    endtask

    task automatic drain(string name);
        in_valid = 1'b0;
        while (out_valid) @(negedge clk);
        tests++;
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        #(wd_cycles * 20);
        $display("watchdog expired before all tests completed");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        exe_inst_t i;
        word_t     r;
        drv = '0;
        in_valid = 1'b0;
        out_allowin = 1'b1;
        stall_en = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int k = 0; k < 12; k++) issue(mk(alu_op_t'(1) << k, rnd(), rnd()));
        drain("reset_and_alu");

        r = rnd();
        i = mk(alu_op_t'(1) << alu_add, rnd(), rnd());
        i.src2_is_imm = 1'b1;
        i.imm = r[15:0] | 16'h8000;        // negative immediate
        issue(i);
        i.alu_op = alu_op_t'(1) << alu_and;
        issue(i);
        i.alu_op = alu_op_t'(1) << alu_or;
        issue(i);
        i.alu_op = alu_op_t'(1) << alu_xor;
        issue(i);
        i = mk(alu_op_t'(1) << alu_sll, rnd(), rnd());
        i.src1_is_sa = 1'b1;
        i.imm = r[31:16];
        issue(i);
        i = mk(alu_op_t'(1) << alu_add, rnd(), rnd());
        i.src1_is_pc = 1'b1;
        i.src2_is_8 = 1'b1;
        i.pc = rnd();
        issue(i);
        drain("operand_select");

        for (int n = 0; n < 12; n++) begin
            i = mk('0, rnd(), rnd());
            i.gpr_we = 1'b0;
            if (n % 2 == 0) i.hilo_op.mult = 1'b1;
            else i.hilo_op.multu = 1'b1;
            issue(i);
            i = mk('0, rnd(), rnd());
            i.hilo_op.mfhi = 1'b1;
            issue(i);
            i.hilo_op = '0;
            i.hilo_op.mflo = 1'b1;
            issue(i);
        end
        i = mk('0, rnd(), 0);
        i.hilo_op.mthi = 1'b1;
        issue(i);
        i = mk('0, rnd(), 0);
        i.hilo_op.mtlo = 1'b1;
        issue(i);
        i.hilo_op = '0;
        i.hilo_op.mfhi = 1'b1;
        issue(i);
        i.hilo_op = '0;
        i.hilo_op.mflo = 1'b1;
        issue(i);
        drain("hilo");

        for (int k = 0; k < 5; k++) begin
            for (int a = 0; a < 4; a++) begin
                i = mk(alu_op_t'(1) << alu_add, rnd() & ~32'd3, rnd());
                i.src2_is_imm = 1'b1;
                i.imm = 16'(a);
                i.mem_we = 1'b1;
                i.gpr_we = 1'b0;
                i.ls_type = ls_type_t'(1) << k;
                issue(i);
            end
        end
        i.mem_we = 1'b0;
        i.mem_re = 1'b1;                    // a load, no strobes
        i.gpr_we = 1'b1;
        issue(i);
        drain("stores");

        stall_en = 1'b1;
        for (int n = 0; n < 30; n++) begin
            r = rnd();
            i = mk(alu_op_t'(1) << (r % 12), rnd(), rnd());
            if (r[20]) begin
                i.alu_op = alu_op_t'(1) << alu_add;
                i.src2_is_imm = 1'b1;
                i.imm = r[31:16];
                i.mem_we = 1'b1;
                i.ls_type = ls_type_t'(1) << (r[7:4] % 5);
            end
            issue(i);
        end
        in_valid = 1'b0;
        stall_en = 1'b0;
        @(negedge clk);
        out_allowin = 1'b1;
        drain("back_pressure");

        if (accepts != total_issue || fires != accepts) begin
            errors++;
            $display("instruction count mismatch, %0d issued, %0d accepted and %0d fired",
                     total_issue, accepts, fires);
        end
        $display("%0d tests run, %0d instructions, %0d errors", tests, fires, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
